// File: hdl/mist_defines.svh
`ifndef MIST_DEFINES_SVH
`define MIST_DEFINES_SVH

// ioctl byte address as sent by the io controller
`define IOCTL_AW 22

// rom store word address, 1024 words of 16 bits
`define ROM_AW 10

// video frame geometry in pixels and lines
`define H_TOTAL 64
`define V_TOTAL 32
`define HS_LEN 6
`define VS_LEN 2

// clk cycles per pixel
`define PXL_DIV 4

`endif

// File: hdl/mist_pkg.sv
`default_nettype none

`include "mist_defines.svh"

package mist_pkg;

    // first byte of an SS2 frame
    localparam logic [7:0] CMD_DL_CTRL = 8'h54;
    localparam logic [7:0] CMD_DL_DATA = 8'h55;

    // position inside the current SS2 frame
    typedef enum logic [1:0] {
        IDLE,
        CMD,
        CTRL_ARG,
        DATA
    } dl_state_t;

    typedef logic [`IOCTL_AW-1:0] ioctl_addr_t;

endpackage

`default_nettype wire

// File: hdl/spi_byte_rx.sv
`timescale 1ns/10ps
`default_nettype none

module spi_byte_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       spi_sck,
    input  logic       spi_ss2,
    input  logic       spi_di,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       frame_start
);

    logic [1:0] sck_sync;
    logic [1:0] ss2_sync;
    logic [1:0] di_sync;
    logic       sck_d;
    logic       ss2_d;
    logic       ss2_fall;
    logic       sck_rise_q;
    logic       di_q;
    logic [7:0] shreg;
    logic [2:0] bit_cnt;
    logic       byte_done;

    assign ss2_fall = ~ss2_sync[1] & ss2_d;

    // sck and ss2 cross into clk here, ss2 idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            sck_sync   <= 2'b00;
            ss2_sync   <= 2'b11;
            sck_d      <= 1'b0;
            ss2_d      <= 1'b1;
            sck_rise_q <= 1'b0;
        end else begin
            sck_sync   <= {sck_sync[0], spi_sck};
            ss2_sync   <= {ss2_sync[0], spi_ss2};
            sck_d      <= sck_sync[1];
            ss2_d      <= ss2_sync[1];
            sck_rise_q <= sck_sync[1] & ~sck_d & ~ss2_sync[1];
        end
    end

    // di follows the same two flops so it lines up with the sck edge
    always_ff @(posedge clk) begin
        di_sync <= {di_sync[0], spi_di};
        di_q    <= di_sync[1];
        if (sck_rise_q) begin
            shreg <= {shreg[6:0], di_q};
        end
        if (byte_done) begin
            rx_byte <= shreg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt     <= 3'd0;
            byte_done   <= 1'b0;
            rx_valid    <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            byte_done   <= 1'b0;
            rx_valid    <= byte_done;
            frame_start <= ss2_fall;
            if (ss2_sync[1] || ss2_fall) begin
                bit_cnt <= 3'd0;
            end else if (sck_rise_q) begin
                bit_cnt   <= bit_cnt + 3'd1;
                byte_done <= (bit_cnt == 3'd7);
            end
        end
    end

    // a byte only completes while the frame is open
    assert property (@(posedge clk) disable iff (rst)
        rx_valid |-> !ss2_sync[1]);

endmodule

`default_nettype wire

// File: hdl/ioctl_download.sv
`timescale 1ns/10ps
`default_nettype none

module ioctl_download (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            rx_byte,
    input  logic                  rx_valid,
    input  logic                  frame_start,
    output logic                  downloading,
    output logic                  ioctl_wr,
    output mist_pkg::ioctl_addr_t ioctl_addr,
    output logic [7:0]            ioctl_data
);

    mist_pkg::dl_state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= mist_pkg::IDLE;
            downloading <= 1'b0;
            ioctl_wr    <= 1'b0;
            ioctl_addr  <= '0;
        end else begin
            ioctl_wr <= 1'b0;
            // advance once the previous write has gone out
            if (ioctl_wr) begin
                ioctl_addr <= ioctl_addr + 1'b1;
            end
            if (frame_start) begin
                state <= mist_pkg::CMD;
            end else if (rx_valid) begin
                case (state)
                    mist_pkg::CMD: begin
                        if (rx_byte == mist_pkg::CMD_DL_CTRL) begin
                            state <= mist_pkg::CTRL_ARG;
                        end else if (rx_byte == mist_pkg::CMD_DL_DATA && downloading) begin
                            state <= mist_pkg::DATA;
                        end else begin
                            // unknown command or data with no load running
                            state <= mist_pkg::IDLE;
                        end
                    end
                    mist_pkg::CTRL_ARG: begin
                        downloading <= (rx_byte != 8'h00);
                        if (rx_byte != 8'h00) begin
                            ioctl_addr <= '0;
                        end
                        state <= mist_pkg::IDLE;
                    end
                    mist_pkg::DATA: begin
                        ioctl_wr <= 1'b1;
                    end
                    default: begin
                        state <= mist_pkg::IDLE;
                    end
                endcase
            end
        end
    end

    // write data is sampled with the strobe
    always_ff @(posedge clk) begin
        if (rx_valid && state == mist_pkg::DATA) begin
            ioctl_data <= rx_byte;
        end
    end

    // writes only happen during a load
    assert property (@(posedge clk) disable iff (rst)
        ioctl_wr |-> downloading);

endmodule

`default_nettype wire

// File: hdl/rom_word_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "mist_defines.svh"

module rom_word_store (
    input  logic                  clk,
    input  logic                  ioctl_wr,
    input  mist_pkg::ioctl_addr_t ioctl_addr,
    input  logic [7:0]            ioctl_data,
    input  logic [`ROM_AW-1:0]    rom_addr,
    input  logic                  rom_rd,
    output logic [15:0]           rom_data
);

    localparam int WORDS = 2 ** `ROM_AW;

    logic [15:0]        mem [WORDS];
    logic [`ROM_AW-1:0] wr_word;
    logic               in_range;
    logic               hi_lane;

    // byte address bit 0 picks the lane
    assign wr_word  = ioctl_addr[`ROM_AW:1];
    assign hi_lane  = ioctl_addr[0];

    // bytes past the end are dropped, not wrapped onto word 0
    assign in_range = (ioctl_addr[`IOCTL_AW-1:`ROM_AW+1] == '0);

    always_ff @(posedge clk) begin
        if (ioctl_wr && in_range) begin
            if (hi_lane) begin
                mem[wr_word][15:8] <= ioctl_data;
            end else begin
                mem[wr_word][7:0] <= ioctl_data;
            end
        end
    end

    // game side read, rom_data holds between reads
    always_ff @(posedge clk) begin
        if (rom_rd) begin
            rom_data <= mem[rom_addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/video_sync.sv
`timescale 1ns/10ps
`default_nettype none

`include "mist_defines.svh"

module video_sync (
    input  logic        clk,
    input  logic        rst,
    input  logic        hold,
    output logic        pxl_cen,
    output logic        hs,
    output logic        vs,
    output logic [31:0] frame_cnt
);

    localparam int DW = $clog2(`PXL_DIV);
    localparam int HW = $clog2(`H_TOTAL);
    localparam int VW = $clog2(`V_TOTAL);

    logic [DW-1:0] div;
    logic [HW-1:0] h_cnt;
    logic [HW-1:0] h_next;
    logic [VW-1:0] v_cnt;
    logic [VW-1:0] v_next;
    logic          line_end;
    logic          frame_wrap;

    always_comb begin
        line_end   = (h_cnt == HW'(`H_TOTAL - 1));
        h_next     = line_end ? '0 : h_cnt + 1'b1;
        v_next     = (v_cnt == VW'(`V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        frame_wrap = pxl_cen && line_end && (v_next == '0);
    end

    always_ff @(posedge clk) begin
        if (rst || hold) begin
            div     <= '0;
            pxl_cen <= 1'b0;
            h_cnt   <= '0;
            v_cnt   <= '0;
            hs      <= 1'b1;
            vs      <= 1'b1;
        end else begin
            div     <= (div == DW'(`PXL_DIV - 1)) ? '0 : div + 1'b1;
            pxl_cen <= (div == DW'(`PXL_DIV - 1));
            if (pxl_cen) begin
                h_cnt <= h_next;
                // sync edges set on entering the line or frame start
                if (h_next == '0) begin
                    hs <= 1'b0;
                end else if (h_next == HW'(`HS_LEN)) begin
                    hs <= 1'b1;
                end
                if (line_end) begin
                    v_cnt <= v_next;
                    if (v_next == '0) begin
                        vs <= 1'b0;
                    end else if (v_next == VW'(`VS_LEN)) begin
                        vs <= 1'b1;
                    end
                end
            end
        end
    end

    // kept across a hold, cleared only by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_cnt <= '0;
        end else if (!hold && frame_wrap) begin
            frame_cnt <= frame_cnt + 32'd1;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        ($changed(hs) || $changed(vs)) |-> $past(pxl_cen) || $past(hold));

endmodule

`default_nettype wire

// File: hdl/mist_core_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mist_defines.svh"

module mist_core_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               spi_sck,
    input  logic               spi_ss2,
    input  logic               spi_di,
    input  logic [`ROM_AW-1:0] rom_addr,
    input  logic               rom_rd,
    output logic               downloading,
    output logic [15:0]        rom_data,
    output logic               pxl_cen,
    output logic               hs,
    output logic               vs,
    output logic [31:0]        frame_cnt
);

    logic [7:0]            rx_byte;
    logic                  rx_valid;
    logic                  frame_start;
    logic                  ioctl_wr;
    mist_pkg::ioctl_addr_t ioctl_addr;
    logic [7:0]            ioctl_data;

    // SPI from the io controller, SS2 carries the rom
    spi_byte_rx u_spi (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .spi_sck     ( spi_sck     ),
        .spi_ss2     ( spi_ss2     ),
        .spi_di      ( spi_di      ),
        .rx_byte     ( rx_byte     ),
        .rx_valid    ( rx_valid    ),
        .frame_start ( frame_start )
    );

    ioctl_download u_download (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .rx_byte     ( rx_byte     ),
        .rx_valid    ( rx_valid    ),
        .frame_start ( frame_start ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  )
    );

    rom_word_store u_rom (
        .clk         ( clk         ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .rom_addr    ( rom_addr    ),
        .rom_rd      ( rom_rd      ),
        .rom_data    ( rom_data    )
    );

    // game video stays frozen while the rom loads
    video_sync u_video (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .hold        ( downloading ),
        .pxl_cen     ( pxl_cen     ),
        .hs          ( hs          ),
        .vs          ( vs          ),
        .frame_cnt   ( frame_cnt   )
    );

endmodule

`default_nettype wire

// File: verification/mist_tb_tasks.svh
`ifndef MIST_TB_TASKS_SVH
`define MIST_TB_TASKS_SVH

task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
endtask

task automatic expect_value(input string test, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else stop_with_failure(
        $sformatf("ERROR %s: expected 0x%0h, actual 0x%0h", test, expected, actual));
endtask

// inputs change 2 ns after the rising edge
task automatic step_clk();
    @(posedge clk);
    #2;
endtask

// mode 0, msb first, sck at clk/8
task automatic spi_send_byte(input logic [7:0] b);
    int i;
    for (i = 7; i >= 0; i--) begin
        spi_di  = b[i];
        spi_sck = 1'b0;
        repeat (SPI_HALF) @(posedge clk);
        #2;
        spi_sck = 1'b1;
        repeat (SPI_HALF) @(posedge clk);
        #2;
    end
endtask

task automatic spi_send_frame(input logic [7:0] cmd);
    int i;
    spi_ss2 = 1'b0;
    spi_sck = 1'b0;
    repeat (SPI_HALF) @(posedge clk);
    #2;
    spi_send_byte(cmd);
    for (i = 0; i < tx_len; i++) begin
        spi_send_byte(tx_buf[i]);
    end
    // let the last byte drain before the frame closes
    spi_sck = 1'b0;
    repeat (2 * SPI_HALF) @(posedge clk);
    #2;
    spi_ss2 = 1'b1;
    repeat (2 * SPI_HALF) @(posedge clk);
    #2;
endtask

task automatic wait_dl_level(input string test, input logic level);
    int n;
    n = 0;
    while (downloading !== level && n < 64) begin
        step_clk();
        n++;
    end
    if (downloading !== level) begin
        stop_with_failure($sformatf("%s: downloading did not go to %0d in time", test, level));
    end
endtask

task automatic wait_frame_change(input string test, output int cycles);
    logic [31:0] start;
    start  = frame_cnt;
    cycles = 0;
    while (frame_cnt === start && cycles < 2 * FRAME_CLKS) begin
        step_clk();
        cycles++;
    end
    if (frame_cnt === start) begin
        stop_with_failure($sformatf("%s: frame counter never advanced", test));
    end
endtask

task automatic wait_hs_low(input string test);
    int n;
    n = 0;
    while (hs !== 1'b0 && n < LINE_CLKS + 64) begin
        step_clk();
        n++;
    end
    if (hs !== 1'b0) begin
        stop_with_failure($sformatf("%s: no hsync pulse after the hold was released", test));
    end
endtask

// control frame, the model start clears the byte address
task automatic send_ctrl(input string test, input logic [7:0] arg);
    tx_buf[0] = arg;
    tx_len    = 1;
    spi_send_frame(mist_pkg::CMD_DL_CTRL);
    model_dl = (arg != 8'h00);
    if (model_dl) begin
        model_addr = 0;
    end
    wait_dl_level(test, model_dl);
endtask

task automatic send_data(input logic [7:0] cmd, input int count);
    logic [31:0] rnd;
    int          i;
    for (i = 0; i < count; i++) begin
        rnd       = $random(seed);
        tx_buf[i] = rnd[7:0];
    end
    tx_len = count;
    spi_send_frame(cmd);
    // only data during a load lands, bytes past the end are lost
    if (cmd == mist_pkg::CMD_DL_DATA && model_dl) begin
        for (i = 0; i < count; i++) begin
            if (model_addr < ROM_BYTES) begin
                shadow[model_addr] = tx_buf[i];
            end
            model_addr++;
        end
    end
endtask

task automatic read_word(input logic [`ROM_AW-1:0] addr, output logic [15:0] data);
    rom_addr = addr;
    rom_rd   = 1'b1;
    step_clk();
    rom_rd = 1'b0;
    data   = rom_data;
endtask

task automatic check_words(input string test, input int first, input int count);
    int          w;
    logic [15:0] got;
    for (w = first; w < first + count; w++) begin
        read_word(`ROM_AW'(w), got);
        expect_value(test, 32'({shadow[2 * w + 1], shadow[2 * w]}), 32'(got));
    end
endtask

task automatic test_reset();
    int cycles;
    expect_value("test_reset", 0, 32'(downloading));
    expect_value("test_reset", 1, 32'(hs));
    expect_value("test_reset", 1, 32'(vs));
    expect_value("test_reset", 0, frame_cnt);
    wait_frame_change("test_reset", cycles);
    expect_value("test_reset", 1, frame_cnt);
    // vs falls on the same pixel
    expect_value("test_reset", 0, 32'(vs));
    assert (cycles > FRAME_CLKS - 64 && cycles <= FRAME_CLKS + 64) else stop_with_failure(
        $sformatf("ERROR test_reset: expected frame after %0d cycles, actual %0d",
                  FRAME_CLKS, cycles));
endtask

task automatic test_download_ctrl();
    logic [31:0] held;
    int          n;
    send_ctrl("test_download_ctrl", 8'hff);
    held = frame_cnt;
    // video frozen for a few line times
    for (n = 0; n < 4 * LINE_CLKS; n++) begin
        step_clk();
        expect_value("test_download_ctrl", 1, 32'(hs));
        expect_value("test_download_ctrl", 0, 32'(pxl_cen));
        expect_value("test_download_ctrl", held, frame_cnt);
    end
    send_ctrl("test_download_ctrl", 8'h00);
    wait_hs_low("test_download_ctrl");
endtask

task automatic test_load_readback();
    logic [15:0] got;
    send_ctrl("test_load_readback", 8'h01);
    send_data(mist_pkg::CMD_DL_DATA, 64);
    send_ctrl("test_load_readback", 8'h00);
    check_words("test_load_readback", 0, 32);
    // output keeps the last read while rom_rd is low
    read_word(`ROM_AW'(5), got);
    expect_value("test_load_readback", 32'({shadow[11], shadow[10]}), 32'(got));
    rom_addr = `ROM_AW'(6);
    step_clk();
    step_clk();
    expect_value("test_load_readback", 32'({shadow[11], shadow[10]}), 32'(rom_data));
endtask

task automatic test_ignored_data();
    send_ctrl("test_ignored_data", 8'h01);
    send_data(8'h5a, 16);
    send_ctrl("test_ignored_data", 8'h00);
    check_words("test_ignored_data", 0, 32);
    // byte address is back at 0, so a stray write would hit word 0
    send_data(mist_pkg::CMD_DL_DATA, 16);
    check_words("test_ignored_data", 0, 32);
endtask

task automatic test_bound();
    logic [15:0] got;
    logic [15:0] first_pair;
    send_ctrl("test_bound", 8'h01);
    send_data(mist_pkg::CMD_DL_DATA, ROM_BYTES + 4);
    first_pair = {tx_buf[1], tx_buf[0]};
    send_ctrl("test_bound", 8'h00);
    check_words("test_bound", 0, ROM_BYTES / 2);
    // word 0 keeps the first pair
    read_word(`ROM_AW'(0), got);
    expect_value("test_bound", 32'(first_pair), 32'(got));
endtask

task automatic test_restart();
    send_ctrl("test_restart", 8'h01);
    send_data(mist_pkg::CMD_DL_DATA, 16);
    send_ctrl("test_restart", 8'h01);
    send_data(mist_pkg::CMD_DL_DATA, 32);
    send_ctrl("test_restart", 8'h00);
    check_words("test_restart", 0, 64);
endtask

`endif

// File: verification/mist_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mist_defines.svh"

module mist_tb;

    localparam int ROM_BYTES  = 2 * (2 ** `ROM_AW);
    localparam int LINE_CLKS  = `H_TOTAL * `PXL_DIV;
    localparam int FRAME_CLKS = `V_TOTAL * LINE_CLKS;
    localparam int SPI_HALF   = 4;

    logic               clk;
    logic               rst;
    logic               spi_sck;
    logic               spi_ss2;
    logic               spi_di;
    logic [`ROM_AW-1:0] rom_addr;
    logic               rom_rd;
    logic               downloading;
    logic [15:0]        rom_data;
    logic               pxl_cen;
    logic               hs;
    logic               vs;
    logic [31:0]        frame_cnt;

    // shadow rom and the loader state it follows
    logic [7:0] shadow [ROM_BYTES];
    logic [7:0] tx_buf [ROM_BYTES + 16];
    int         tx_len;
    int         model_addr;
    logic       model_dl;
    int         seed;

    mist_core_top mist_core_top_inst (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .spi_sck     ( spi_sck     ),
        .spi_ss2     ( spi_ss2     ),
        .spi_di      ( spi_di      ),
        .rom_addr    ( rom_addr    ),
        .rom_rd      ( rom_rd      ),
        .downloading ( downloading ),
        .rom_data    ( rom_data    ),
        .pxl_cen     ( pxl_cen     ),
        .hs          ( hs          ),
        .vs          ( vs          ),
        .frame_cnt   ( frame_cnt   )
    );

    // 20 ns clock
    always #10 clk = ~clk;

    `include "mist_tb_tasks.svh"

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        spi_sck    = 1'b0;
        spi_ss2    = 1'b1;
        spi_di     = 1'b0;
        rom_addr   = '0;
        rom_rd     = 1'b0;
        tx_len     = 0;
        model_addr = 0;
        model_dl   = 1'b0;
        seed       = 45;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        step_clk();
        test_reset();
        test_download_ctrl();
        test_load_readback();
        test_ignored_data();
        test_bound();
        test_restart();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
+incdir+verification
hdl/mist_pkg.sv
hdl/spi_byte_rx.sv
hdl/ioctl_download.sv
hdl/rom_word_store.sv
hdl/video_sync.sv
hdl/mist_core_top.sv
verification/mist_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module mist_tb
	./obj_dir/Vmist_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
